// ==== crc_check_pkg.sv ====
// ==================================================================
// CRC check shared types
// Link word, lane, CRC values, validation packet and control state
// ==================================================================

package crc_check_pkg;

   // One link data word as carried by the stream
   typedef logic [63:0] data_word_t;

   // Slice of a data word folded into one engine per beat
   typedef logic [15:0] lane_t;

   // CRC value widths
   typedef logic [15:0] crc16_t;
   typedef logic [7:0]  crc8_t;

   // Validation packet layout, most significant field first
   typedef struct packed {
      logic [7:0] reserved;
      crc8_t      crcvw;
      crc16_t     crc45;
      crc16_t     crc23;
      crc16_t     crc01;
   } vd_pkt_t;

   // Computed CRCs of one frame, one per lane engine
   typedef struct packed {
      crc16_t crc01;
      crc16_t crc23;
      crc16_t crc45;
      crc8_t  crcvw;
   } crc_set_t;

   // Control FSM states
   typedef enum logic {
      ST_INIT,
      ST_STREAM
   } ctrl_state_t;

endpackage

// ==== crc_lane_engine.sv ====
// ==================================================================
// CRC lane engine
// Folds one 16-bit lane per beat into a running CRC, MSB first
// ==================================================================

module crc_lane_engine #(
   parameter int unsigned      CRC_W = 16,
   parameter logic [CRC_W-1:0] POLY  = 16'h1021,
   parameter logic [CRC_W-1:0] INIT  = 16'hFFFF
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  crc_check_pkg::lane_t  lane_i,
   input  logic                  beat_en_i,
   input  logic                  restart_i,
   output logic [CRC_W-1:0]      crc_o
);

   import crc_check_pkg::*;

   localparam int unsigned LANE_W = $bits(lane_t);

   // Running CRC of the frame in progress
   logic [CRC_W-1:0] crc_q;

   // Unrolled equivalent of LANE_W serial shifts
   function automatic logic [CRC_W-1:0] crc_fold(
      input logic [CRC_W-1:0] crc_in,
      input lane_t            lane
   );
      logic [CRC_W-1:0] crc;
      logic             fb;
      crc = crc_in;
      for (int i = LANE_W - 1; i >= 0; i--) begin
         fb  = crc[CRC_W-1] ^ lane[i];
         crc = {crc[CRC_W-2:0], 1'b0};
         if (fb) begin
            crc = crc ^ POLY;
         end
      end
      return crc;
   endfunction

   // Restart is held by control through reset, so crc_q starts at INIT
   always_ff @(posedge clk_i) begin
      if (restart_i) begin
         // Finished frame goes out, next frame starts from INIT
         crc_o <= crc_q;
         crc_q <= INIT;
      end else if (beat_en_i) begin
         crc_q <= crc_fold(crc_q, lane_i);
      end
   end

   // A boundary beat never carries lane data into the CRC
   a_no_step_on_restart :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(beat_en_i && restart_i))
   else $fatal(1, "beat_en_i and restart_i both high at %m");

endmodule

// ==== crc_check_ctrl.sv ====
// ==================================================================
// CRC check control
// Stream handshake, frame boundary decode and check strobes
// ==================================================================

module crc_check_ctrl (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic s_tvalid_i,
   input  logic s_boundary_i,
   output logic s_tready_o,
   output logic beat_en_o,
   output logic restart_o,
   output logic crc_boundary_o,
   output logic crc_valid_o
);

   import crc_check_pkg::*;

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   logic        accept;
   logic        crc_valid_q;

   // ST_INIT lasts one cycle so the engines load their initial value
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_INIT: begin
            state_d = ST_STREAM;
         end
         ST_STREAM: begin
            state_d = ST_STREAM;
         end
         default: begin
            state_d = ST_INIT;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_INIT;
      end else begin
         state_q <= state_d;
      end
   end

   assign s_tready_o = (state_q == ST_STREAM);
   assign accept     = s_tvalid_i && s_tready_o;

   // Decode of each accepted beat
   assign beat_en_o      = accept && !s_boundary_i;
   assign crc_boundary_o = accept && s_boundary_i;
   assign restart_o      = crc_boundary_o || (state_q == ST_INIT);

   // Engine outputs settle one cycle after the boundary
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_valid_q <= 1'b0;
      end else begin
         crc_valid_q <= crc_boundary_o;
      end
   end

   assign crc_valid_o = crc_valid_q;

   a_valid_follows_boundary :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      crc_valid_o == $past(crc_boundary_o))
   else $fatal(1, "crc_valid_o not one cycle after crc_boundary_o at %m");

   a_beat_boundary_excl :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(beat_en_o && crc_boundary_o))
   else $fatal(1, "beat_en_o and crc_boundary_o both high at %m");

endmodule

// ==== crc_vd_compare.sv ====
// ==================================================================
// Validation packet compare
// Matches the received packet against the computed CRC set
// ==================================================================

module crc_vd_compare (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  crc_check_pkg::data_word_t tdata_i,
   input  logic                      crc_boundary_i,
   input  logic                      crc_valid_i,
   input  crc_check_pkg::crc_set_t   crc_i,
   output logic                      check_done_o,
   output logic                      crc_error_o
);

   import crc_check_pkg::*;

   vd_pkt_t  pkt_q;
   vd_pkt_t  s1_pkt;
   crc_set_t s1_crc;
   logic     s1_valid;
   logic     s1_mismatch;
   logic     done_q;
   logic     error_q;

   // Packet arrives on the boundary beat
   always_ff @(posedge clk_i) begin
      if (crc_boundary_i) begin
         pkt_q <= vd_pkt_t'(tdata_i);
      end
   end

   // Stage 1 pairs the packet with its frame's CRCs
   always_ff @(posedge clk_i) begin
      if (crc_valid_i) begin
         s1_pkt <= pkt_q;
         s1_crc <= crc_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= crc_valid_i;
      end
   end

   // Reserved byte takes no part in the check
   assign s1_mismatch = (s1_pkt.crc01 != s1_crc.crc01) ||
                        (s1_pkt.crc23 != s1_crc.crc23) ||
                        (s1_pkt.crc45 != s1_crc.crc45) ||
                        (s1_pkt.crcvw != s1_crc.crcvw);

   // Stage 2 result pulses
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         done_q  <= 1'b0;
         error_q <= 1'b0;
      end else begin
         done_q  <= s1_valid;
         error_q <= s1_valid && s1_mismatch;
      end
   end

   assign check_done_o = done_q;
   assign crc_error_o  = error_q;

   a_error_needs_done :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      crc_error_o |-> check_done_o)
   else $fatal(1, "crc_error_o without check_done_o at %m");

endmodule

// ==== crc_check_checker.sv ====
// ==================================================================
// CRC check assertion checker
// Timing of the boundary, CRC-valid and done strobes, error value
// ==================================================================

module crc_check_checker (
   input logic                      clk_i,
   input logic                      rst_n_i,
   input logic                      crc_boundary_i,
   input logic                      crc_valid_i,
   input logic                      check_done_i,
   input logic                      crc_error_i,
   input crc_check_pkg::data_word_t tdata_i,
   input crc_check_pkg::crc_set_t   crc_i
);

   import crc_check_pkg::*;

   // Own copy of the last validation packet
   vd_pkt_t vd_pkt;

   always_ff @(posedge clk_i) begin
      if (crc_boundary_i) begin
         vd_pkt <= vd_pkt_t'(tdata_i);
      end
   end

   function automatic logic pkt_mismatch(input vd_pkt_t p, input crc_set_t c);
      return (p.crc01 != c.crc01) || (p.crc23 != c.crc23) ||
             (p.crc45 != c.crc45) || (p.crcvw != c.crcvw);
   endfunction

   c_check_done :
   cover property (@(posedge clk_i) check_done_i);

   c_crc_error :
   cover property (@(posedge clk_i) crc_error_i);

   // Valid at T+1, done at T+3
   a_done_delay :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      crc_boundary_i |-> ##1 crc_valid_i ##2 check_done_i)
   else $fatal(1, "check_done_i timing violation at %m");

   a_no_spurious_done :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      check_done_i |-> $past(crc_valid_i, 2) && $past(crc_boundary_i, 3))
   else $fatal(1, "Spurious check_done_i at %m");

   a_no_spurious_error :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      crc_error_i |-> check_done_i)
   else $fatal(1, "Spurious crc_error_i at %m");

   // Packet and CRC set as they stood at the T+1 edge
   a_error_correct :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      check_done_i |-> crc_error_i == pkt_mismatch($past(vd_pkt, 2), $past(crc_i, 2)))
   else $fatal(1, "crc_error_i correctness violation at %m");

endmodule

// ==== crc_check_top.sv ====
// ==================================================================
// CRC check top level
// Control, four lane engines, packet compare and assertion checker
// ==================================================================

module crc_check_top #(
   parameter crc_check_pkg::crc16_t CRC16_POLY = 16'h1021,
   parameter crc_check_pkg::crc16_t CRC16_INIT = 16'hFFFF,
   parameter crc_check_pkg::crc8_t  CRC8_POLY  = 8'h07,
   parameter crc_check_pkg::crc8_t  CRC8_INIT  = 8'hFF
) (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  crc_check_pkg::data_word_t s_tdata_i,
   input  logic                      s_tvalid_i,
   input  logic                      s_boundary_i,
   output logic                      s_tready_o,
   output logic                      check_done_o,
   output logic                      crc_error_o
);

   import crc_check_pkg::*;

   logic     beat_en;
   logic     restart;
   logic     crc_boundary;
   logic     crc_valid;
   crc_set_t crc_set;

   crc_check_ctrl u_ctrl (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .s_tvalid_i    (s_tvalid_i),
      .s_boundary_i  (s_boundary_i),
      .s_tready_o    (s_tready_o),
      .beat_en_o     (beat_en),
      .restart_o     (restart),
      .crc_boundary_o(crc_boundary),
      .crc_valid_o   (crc_valid)
   );

   // Bytes 0-1
   crc_lane_engine #(
      .CRC_W(16),
      .POLY (CRC16_POLY),
      .INIT (CRC16_INIT)
   ) u_crc01 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .lane_i   (lane_t'(s_tdata_i[15:0])),
      .beat_en_i(beat_en),
      .restart_i(restart),
      .crc_o    (crc_set.crc01)
   );

   // Bytes 2-3
   crc_lane_engine #(
      .CRC_W(16),
      .POLY (CRC16_POLY),
      .INIT (CRC16_INIT)
   ) u_crc23 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .lane_i   (lane_t'(s_tdata_i[31:16])),
      .beat_en_i(beat_en),
      .restart_i(restart),
      .crc_o    (crc_set.crc23)
   );

   // Bytes 4-5
   crc_lane_engine #(
      .CRC_W(16),
      .POLY (CRC16_POLY),
      .INIT (CRC16_INIT)
   ) u_crc45 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .lane_i   (lane_t'(s_tdata_i[47:32])),
      .beat_en_i(beat_en),
      .restart_i(restart),
      .crc_o    (crc_set.crc45)
   );

   // Bytes 6-7 use the short CRC
   crc_lane_engine #(
      .CRC_W(8),
      .POLY (CRC8_POLY),
      .INIT (CRC8_INIT)
   ) u_crcvw (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .lane_i   (lane_t'(s_tdata_i[63:48])),
      .beat_en_i(beat_en),
      .restart_i(restart),
      .crc_o    (crc_set.crcvw)
   );

   crc_vd_compare u_compare (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .tdata_i       (s_tdata_i),
      .crc_boundary_i(crc_boundary),
      .crc_valid_i   (crc_valid),
      .crc_i         (crc_set),
      .check_done_o  (check_done_o),
      .crc_error_o   (crc_error_o)
   );

   crc_check_checker u_checker (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .crc_boundary_i(crc_boundary),
      .crc_valid_i   (crc_valid),
      .check_done_i  (check_done_o),
      .crc_error_i   (crc_error_o),
      .tdata_i       (s_tdata_i),
      .crc_i         (crc_set)
   );

endmodule

// ==== tb_crc_check.sv ====
// ======================================================================
// Testbench for the CRC check top level
// Random frames with clean or corrupted validation packets
// ======================================================================

module tb_crc_check;

   timeunit 1ns;
   timeprecision 1ps;

   import crc_check_pkg::*;

   localparam crc16_t CRC16_POLY = 16'h1021;
   localparam crc16_t CRC16_INIT = 16'hFFFF;
   localparam crc8_t  CRC8_POLY  = 8'h07;
   localparam crc8_t  CRC8_INIT  = 8'hFF;

   localparam int READY_TIMEOUT = 50;
   localparam int DONE_TIMEOUT  = 200;
   localparam int DONE_LATENCY  = 3;

   logic       clk_i;
   logic       rst_n_i;
   data_word_t s_tdata_i;
   logic       s_tvalid_i;
   logic       s_boundary_i;
   logic       s_tready_o;
   logic       check_done_o;
   logic       crc_error_o;

   logic [31:0] rng_state = 32'd77066;
   logic        gaps_on   = 1'b0;
   int          frames_sent = 0;
   int          done_count  = 0;
   int          edge_cnt    = 0;

   // Expected error bit of each frame in send order
   logic       exp_err_q[$];
   // Accepting edge of each boundary beat
   int         bnd_edge_q[$];

   crc_check_top #(
      .CRC16_POLY(CRC16_POLY),
      .CRC16_INIT(CRC16_INIT),
      .CRC8_POLY (CRC8_POLY),
      .CRC8_INIT (CRC8_INIT)
   ) dut (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .s_tdata_i   (s_tdata_i),
      .s_tvalid_i  (s_tvalid_i),
      .s_boundary_i(s_boundary_i),
      .s_tready_o  (s_tready_o),
      .check_done_o(check_done_o),
      .crc_error_o (crc_error_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // Xorshift32 generator
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // One bit at a time through the CRC shift register, MSB of the lane first
   function automatic crc16_t crc16_lane(input crc16_t crc, input lane_t lane);
      crc16_t r;
      logic   fb;
      r = crc;
      for (int b = 15; b >= 0; b--) begin
         fb = r[15] ^ lane[b];
         r  = (r << 1) ^ (fb ? CRC16_POLY : 16'h0000);
      end
      return r;
   endfunction

   function automatic crc8_t crc8_lane(input crc8_t crc, input lane_t lane);
      crc8_t r;
      logic  fb;
      r = crc;
      for (int b = 15; b >= 0; b--) begin
         fb = r[7] ^ lane[b];
         r  = (r << 1) ^ (fb ? CRC8_POLY : 8'h00);
      end
      return r;
   endfunction

   // Expected CRC set of one frame's data beats
   function automatic crc_set_t ref_crc_set(input data_word_t beats[$]);
      crc_set_t c;
      c.crc01 = CRC16_INIT;
      c.crc23 = CRC16_INIT;
      c.crc45 = CRC16_INIT;
      c.crcvw = CRC8_INIT;
      foreach (beats[i]) begin
         c.crc01 = crc16_lane(c.crc01, beats[i][15:0]);
         c.crc23 = crc16_lane(c.crc23, beats[i][31:16]);
         c.crc45 = crc16_lane(c.crc45, beats[i][47:32]);
         c.crcvw = crc8_lane(c.crcvw, beats[i][63:48]);
      end
      return c;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("ERROR: time %0t: %s = %0b, expected %0b", $time, name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         abort_run($sformatf("ERROR: time %0t: %s = %0d, expected %0d", $time, name, got, exp));
      end
   endtask

   // Optional idle gap, then hold the beat until the DUT accepts it
   task automatic send_beat(input data_word_t word, input logic boundary);
      int unsigned gap;
      int          waited;
      gap = 0;
      if (gaps_on && (next_rand() % 4 == 0)) begin
         gap = 1 + next_rand() % 3;
      end
      for (int unsigned i = 0; i < gap; i++) begin
         s_tvalid_i <= 1'b0;
         @(posedge clk_i);
      end
      s_tvalid_i   <= 1'b1;
      s_tdata_i    <= word;
      s_boundary_i <= boundary;
      waited = 0;
      do begin
         @(posedge clk_i);
         waited++;
      end while (!s_tready_o && waited < READY_TIMEOUT);
      if (!s_tready_o) begin
         abort_run("Timeout: s_tready_o stayed low with a beat pending");
      end
   endtask

   // Mode 0..3 corrupts one CRC field, 4 touches reserved only, others are clean
   task automatic send_frame(input int unsigned n_beats, input int unsigned mode);
      data_word_t  beats[$];
      data_word_t  word;
      crc_set_t    crc;
      vd_pkt_t     pkt;
      logic [31:0] rnd;
      for (int unsigned i = 0; i < n_beats; i++) begin
         word = {next_rand(), next_rand()};
         beats.push_back(word);
         send_beat(word, 1'b0);
      end
      crc = ref_crc_set(beats);
      rnd = next_rand();
      pkt = '0;
      pkt.crc01 = crc.crc01;
      pkt.crc23 = crc.crc23;
      pkt.crc45 = crc.crc45;
      pkt.crcvw = crc.crcvw;
      case (mode)
         0: pkt.crc01 = pkt.crc01 ^ (rnd[15:0] | 16'h0001);
         1: pkt.crc23 = pkt.crc23 ^ (rnd[15:0] | 16'h0001);
         2: pkt.crc45 = pkt.crc45 ^ (rnd[15:0] | 16'h0001);
         3: pkt.crcvw = pkt.crcvw ^ (rnd[7:0] | 8'h01);
         4: pkt.reserved = rnd[7:0] | 8'h01;
         default: begin
         end
      endcase
      // Only a corrupted CRC field flags an error
      exp_err_q.push_back(mode < 4);
      send_beat(data_word_t'(pkt), 1'b1);
      frames_sent++;
   endtask

   // Compare process: sees accepted boundaries and done pulses at each edge
   always @(posedge clk_i) begin : scoreboard
      logic     exp_err;
      int       bnd_edge;
      edge_cnt = edge_cnt + 1;
      if (rst_n_i) begin
         if (crc_error_o && !check_done_o) begin
            abort_run("crc_error_o pulsed without check_done_o");
         end else if (check_done_o && bnd_edge_q.size() == 0) begin
            abort_run("check_done_o pulsed with no frame outstanding");
         end else if (check_done_o) begin
            exp_err  = exp_err_q.pop_front();
            bnd_edge = bnd_edge_q.pop_front();
            check_bit("crc_error_o", crc_error_o, exp_err);
            check_count("check_done_o latency", edge_cnt - bnd_edge, DONE_LATENCY);
            done_count <= done_count + 1;
         end
         if (s_tvalid_i && s_tready_o && s_boundary_i) begin
            bnd_edge_q.push_back(edge_cnt);
         end
      end
   end

   initial begin : stimulus
      int waited;
      rst_n_i      = 1'b0;
      s_tdata_i    = '0;
      s_tvalid_i   = 1'b0;
      s_boundary_i = 1'b0;
      repeat (16) @(posedge clk_i);
      check_bit("s_tready_o", s_tready_o, 1'b0);
      check_bit("check_done_o", check_done_o, 1'b0);
      check_bit("crc_error_o", crc_error_o, 1'b0);
      rst_n_i <= 1'b1;
      @(posedge clk_i);
      // Engines load their initial values in this cycle
      check_bit("s_tready_o", s_tready_o, 1'b0);
      waited = 0;
      while (!s_tready_o && waited < READY_TIMEOUT) begin
         @(posedge clk_i);
         waited++;
      end
      check_bit("s_tready_o", s_tready_o, 1'b1);

      // Each corruption kind once, then clean
      for (int unsigned m = 0; m < 6; m++) begin
         send_frame(3, m);
      end
      // Boundaries on consecutive beats
      send_frame(0, 5);
      send_frame(0, 5);
      send_frame(1, 5);
      send_frame(0, 0);
      send_frame(0, 5);

      gaps_on = 1'b1;
      for (int f = 0; f < 60; f++) begin
         send_frame(next_rand() % 13, next_rand() % 10);
      end
      s_tvalid_i   <= 1'b0;
      s_boundary_i <= 1'b0;

      waited = 0;
      while (done_count != frames_sent && waited < DONE_TIMEOUT) begin
         @(posedge clk_i);
         waited++;
      end
      // Quiet period so a late extra pulse would still be seen
      repeat (8) @(posedge clk_i);
      check_count("check_done_o count", done_count, frames_sent);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== src.f ====
crc_check_pkg.sv
crc_lane_engine.sv
crc_check_ctrl.sv
crc_vd_compare.sv
crc_check_checker.sv
crc_check_top.sv
tb_crc_check.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CRC check testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_crc_check -f src.f \
   > sim.log 2>&1 \
   && ./obj_dir/Vtb_crc_check >> sim.log 2>&1

grep -q "Simulation FAILED" sim.log && { cat sim.log; exit 1; }
grep -q "Simulation PASSED" sim.log || { cat sim.log; echo "No pass message in sim.log"; exit 1; }
echo "Run passed, see sim.log"
exit 0
